// ==== tiny_cpu_trace.txt ====
# L <addr hex> <word hex> loads program memory, E <value hex> queues an expected OUT byte
# R <n decimal> pulses start, program of n words ends in HALT
# Registers right after reset
L 00 060
L 01 064
L 02 068
L 03 06c
L 04 070
E 00
E 00
E 00
E 00
R 5
# LI with both signs, all twelve MOV aliases, NOPs
L 00 111
L 01 004
L 02 009
L 03 068
L 04 17d
L 05 00c
L 06 007
L 07 064
L 08 122
L 09 008
L 0a 00e
L 0b 06c
L 0c 00d
L 0d 003
L 0e 060
L 0f 006
L 10 001
L 11 060
L 12 00b
L 13 002
L 14 060
L 15 005
L 16 00f
L 17 064
L 18 070
E 11
E fd
E 22
E fd
E 22
E fd
E 22
R 25
# ALU ops and wraps, R1 carried over from the previous run
L 00 064
L 01 101
L 02 00c
L 03 13f
L 04 004
L 05 011
L 06 013
L 07 008
L 08 01b
L 09 068
L 0a 100
L 0b 023
L 0c 060
L 0d 031
L 0e 060
L 0f 04b
L 10 068
L 11 056
L 12 016
L 13 064
L 14 070
E 22
E 80
E ff
E 3f
E 81
E 3f
R 21

// ==== tiny_cpu.f ====
tiny_cpu_pkg.sv
instruction_parser.sv
register_file.sv
alu.sv
program_memory.sv
cpu_control.sv
tiny_cpu.sv
tb_tiny_cpu.sv

// ==== Bender.yml ====
package:
  name: tiny_cpu

sources:
  - tiny_cpu_pkg.sv
  - instruction_parser.sv
  - register_file.sv
  - alu.sv
  - program_memory.sv
  - cpu_control.sv
  - tiny_cpu.sv
  - target: simulation
    files:
      - tb_tiny_cpu.sv

// ==== tb_tiny_cpu.sv ====
`default_nettype none

module tb_tiny_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int run_timeout = 200; // Cycles per run before giving up

    logic                                  clk;
    logic                                  arst_n;
    logic                                  prog_we;
    logic [tiny_cpu_pkg::pc_width-1:0]     prog_addr;
    logic [tiny_cpu_pkg::instr_width-1:0]  prog_data;
    logic                                  start;
    logic                                  busy;
    logic                                  done;
    logic                                  out_valid;
    logic [tiny_cpu_pkg::data_width-1:0]   out_data;

    logic [tiny_cpu_pkg::data_width-1:0] expected_q [$]; // OUT values still owed by this run
    int errors;    // Failed checks
    int checks;    // Checks made
    int outs_seen; // out_valid pulses seen
    int runs;      // R records executed
    bit aborted;   // Stops trace reading after a hang

    tiny_cpu dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk; // 10 ns period
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One write cycle through the load port
    task automatic load_word(input logic [tiny_cpu_pkg::pc_width-1:0] addr,
                             input logic [tiny_cpu_pkg::instr_width-1:0] word);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= addr;
        prog_data <= word;
        @(posedge clk);
        prog_we   <= 1'b0;
    endtask

    // Compare one strobe with the oldest pending trace value
    task automatic check_out();
        logic [tiny_cpu_pkg::data_width-1:0] exp_val;
        outs_seen++;
        if (expected_q.size() == 0) begin
            $display("unexpected extra OUT pulse carrying 0x%02h", out_data);
            errors++;
        end else begin
            exp_val = expected_q.pop_front();
            checks++;
            if (out_data !== exp_val) begin
                $display("CHECK FAILED out_data: expected 0x%02h got 0x%02h", exp_val, out_data);
                errors++;
            end
        end
    endtask

    // Start pulse, then watch strobes until done or timeout
    task automatic run_program(input int n_instr);
        int cycles;
        bit finished;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0; // DUT takes start on this edge
        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < run_timeout) begin
            @(negedge clk); // Mid-cycle sample
            if (out_valid) begin
                check_out();
            end
            if (done === 1'b1) begin
                finished = 1'b1;
                checks++;
                if (busy !== 1'b0) begin // Halted core is no longer busy
                    $display("CHECK FAILED busy: expected 0x0 got 0x%0h", busy);
                    errors++;
                end
            end else begin
                cycles++;
                if (busy !== 1'b1) begin
                    $display("CHECK FAILED busy: expected 0x1 got 0x%0h", busy);
                    errors++;
                end
            end
        end
        runs++;
        if (!finished) begin
            $display("timeout: done did not rise within %0d cycles", run_timeout);
            errors++;
            aborted = 1'b1;
        end else begin
            checks++;
            if (cycles != 2 * n_instr) begin
                $display("CHECK FAILED done latency: expected 0x%0h got 0x%0h",
                         2 * n_instr, cycles);
                errors++;
            end
            if (expected_q.size() != 0) begin
                $display("missing OUT pulses: %0d expected values never appeared",
                         expected_q.size());
                errors++;
            end
        end
        expected_q.delete();
    endtask

    initial begin
        int fd;
        int code;
        int n_instr;
        byte kind;
        string line;
        logic [tiny_cpu_pkg::pc_width-1:0]    addr;
        logic [tiny_cpu_pkg::instr_width-1:0] word;
        logic [tiny_cpu_pkg::data_width-1:0]  exp_val;
        void'($urandom(32'h4d3ce9b6));
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start     = 1'b0;
        errors    = 0;
        checks    = 0;
        outs_seen = 0;
        runs      = 0;
        aborted   = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if (busy !== 1'b0 || done !== 1'b0 || out_valid !== 1'b0) begin
            $display("CHECK FAILED reset status: busy 0x%0h done 0x%0h out_valid 0x%0h",
                     busy, done, out_valid);
            errors++;
        end
        fd = $fopen("tiny_cpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errors++;
        end else begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1 && !aborted) begin
                case (kind)
                    "#": code = $fgets(line, fd); // Comment line
                    "L": begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        idle_cycles($urandom % 3); // Random gap between loads
                        load_word(addr, word);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h", exp_val);
                        expected_q.push_back(exp_val);
                    end
                    "R": begin
                        code = $fscanf(fd, "%d", n_instr);
                        idle_cycles($urandom % 4);
                        run_program(n_instr);
                    end
                    default: begin
                        $display("unknown record type in trace file: %c", kind);
                        errors++;
                        aborted = 1'b1;
                    end
                endcase
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
        if (runs == 0) begin
            $display("no program run was found in the trace file");
            errors++;
        end
        $display("runs %0d, checks %0d, out pulses %0d, errors %0d",
                 runs, checks, outs_seen, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tiny_cpu.sv ====
`default_nettype none

module tiny_cpu (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  prog_we,   // Program load strobe
    input  logic [tiny_cpu_pkg::pc_width-1:0]     prog_addr, // Load address
    input  logic [tiny_cpu_pkg::instr_width-1:0]  prog_data, // Load word
    input  logic                                  start,     // One-cycle run pulse
    output logic                                  busy,      // Program running
    output logic                                  done,      // HALT reached
    output logic                                  out_valid, // One-cycle OUT strobe
    output logic [tiny_cpu_pkg::data_width-1:0]   out_data   // OUT value
);

    logic [tiny_cpu_pkg::pc_width-1:0]    pc;         // Fetch address
    logic [tiny_cpu_pkg::instr_width-1:0] instr;      // Registered memory word
    tiny_cpu_pkg::decoded_instr_t         decoded;    // Parser output
    logic [tiny_cpu_pkg::data_width-1:0]  rd_a_data;  // R[r_a]
    logic [tiny_cpu_pkg::data_width-1:0]  rd_b_data;  // R[r_b]
    logic [tiny_cpu_pkg::data_width-1:0]  alu_result; // ALU output
    tiny_cpu_pkg::reg_wr_t                reg_wr;     // Writeback

    program_memory u_program_memory (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (prog_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (pc),
        .rd_data (instr)
    );

    instruction_parser u_instruction_parser (
        .instruction (instr),
        .decoded     (decoded)
    );

    register_file u_register_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (reg_wr),
        .rd_a_addr (decoded.r_a),
        .rd_b_addr (decoded.r_b),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

    alu u_alu (
        .op     (decoded.op),
        .a      (rd_a_data),
        .b      (rd_b_data),
        .result (alu_result)
    );

    cpu_control u_cpu_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .decoded    (decoded),
        .alu_result (alu_result),
        .rd_a_data  (rd_a_data),
        .pc         (pc),
        .reg_wr     (reg_wr),
        .busy       (busy),
        .done       (done),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

// ==== cpu_control.sv ====
`default_nettype none

module cpu_control (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  start,      // One-cycle run request
    input  tiny_cpu_pkg::decoded_instr_t          decoded,    // Current word, valid in EXEC
    input  logic [tiny_cpu_pkg::data_width-1:0]   alu_result, // ALU output
    input  logic [tiny_cpu_pkg::data_width-1:0]   rd_a_data,  // R[r_a] for OUT
    output logic [tiny_cpu_pkg::pc_width-1:0]     pc,         // Program memory read address
    output tiny_cpu_pkg::reg_wr_t                 reg_wr,     // Writeback request
    output logic                                  busy,       // Running
    output logic                                  done,       // Halted
    output logic                                  out_valid,  // OUT strobe
    output logic [tiny_cpu_pkg::data_width-1:0]   out_data    // OUT value
);

    tiny_cpu_pkg::ctrl_state_e state_q;   // Current state
    tiny_cpu_pkg::ctrl_state_e state_d;   // Next state
    logic                      in_exec;   // Executing this cycle
    logic                      wr_op;     // Op writes r_a
    logic                      can_start; // Idle or halted

    assign in_exec   = (state_q == tiny_cpu_pkg::ST_EXEC);
    assign can_start = (state_q == tiny_cpu_pkg::ST_IDLE) ||
                       (state_q == tiny_cpu_pkg::ST_HALTED);

    always_comb begin
        unique case (decoded.op)
            tiny_cpu_pkg::OP_MOV,
            tiny_cpu_pkg::OP_ADD,
            tiny_cpu_pkg::OP_SUB,
            tiny_cpu_pkg::OP_AND,
            tiny_cpu_pkg::OP_OR,
            tiny_cpu_pkg::OP_XOR,
            tiny_cpu_pkg::OP_LI: wr_op = 1'b1;
            default:             wr_op = 1'b0; // NOP, OUT, HALT
        endcase
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            tiny_cpu_pkg::ST_IDLE,
            tiny_cpu_pkg::ST_HALTED: begin
                if (start) begin
                    state_d = tiny_cpu_pkg::ST_FETCH;
                end
            end
            tiny_cpu_pkg::ST_FETCH: state_d = tiny_cpu_pkg::ST_EXEC; // Word now registered
            tiny_cpu_pkg::ST_EXEC: begin
                if (decoded.op == tiny_cpu_pkg::OP_HALT) begin
                    state_d = tiny_cpu_pkg::ST_HALTED;
                end else begin
                    state_d = tiny_cpu_pkg::ST_FETCH;
                end
            end
            default: state_d = tiny_cpu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= tiny_cpu_pkg::ST_IDLE;
            pc      <= '0;
        end else begin
            state_q <= state_d;
            if (can_start && start) begin
                pc <= '0;      // Every run begins at address 0
            end else if (in_exec) begin
                pc <= pc + 1'b1; // Wraps 31 -> 0
            end
        end
    end

    // Writeback lands on the edge that ends EXEC
    assign reg_wr.en   = in_exec && wr_op;
    assign reg_wr.addr = decoded.r_a; // Parser forces R0 for LI
    assign reg_wr.data = (decoded.op == tiny_cpu_pkg::OP_LI) ? decoded.imm : alu_result;

    assign busy      = (state_q == tiny_cpu_pkg::ST_FETCH) || in_exec;
    assign done      = (state_q == tiny_cpu_pkg::ST_HALTED); // Start leaves HALTED
    assign out_valid = in_exec && (decoded.op == tiny_cpu_pkg::OP_OUT);
    assign out_data  = rd_a_data; // Sampled by receiver only with out_valid

    // Receiver takes out_data with the strobe, so it must be a real byte
    a_out_data_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(out_data)
    ) else $error("out_valid with unknown out_data");

    a_busy_done_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(busy && done)
    ) else $error("busy and done high together");

endmodule

`default_nettype wire

// ==== program_memory.sv ====
`default_nettype none

module program_memory (
    input  logic                                   clk,
    input  logic                                   arst_n,  // Clears read register only
    input  logic                                   we,      // Load strobe
    input  logic [tiny_cpu_pkg::pc_width-1:0]      wr_addr, // Load address
    input  logic [tiny_cpu_pkg::instr_width-1:0]   wr_data, // Load word
    input  logic [tiny_cpu_pkg::pc_width-1:0]      rd_addr, // From pc
    output logic [tiny_cpu_pkg::instr_width-1:0]   rd_data  // One cycle after rd_addr
);

    logic [tiny_cpu_pkg::instr_width-1:0] mem [tiny_cpu_pkg::prog_depth]; // Program store

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data; // Loading allowed in any state
        end
    end

    // Registered read, old data on read-during-write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= tiny_cpu_pkg::nop_word; // Decodes harmlessly
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
    input  tiny_cpu_pkg::cpu_op_e                op,     // Decoded operation
    input  logic [tiny_cpu_pkg::data_width-1:0]  a,      // R[r_a]
    input  logic [tiny_cpu_pkg::data_width-1:0]  b,      // R[r_b]
    output logic [tiny_cpu_pkg::data_width-1:0]  result  // Written back to r_a
);

    logic [tiny_cpu_pkg::data_width-1:0] sum;  // a + b, carry dropped
    logic [tiny_cpu_pkg::data_width-1:0] diff; // a - b, borrow dropped

    // Both wrap modulo 256 by truncation
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        unique case (op)
            tiny_cpu_pkg::OP_MOV: begin
                result = b; // Copy source register
            end
            tiny_cpu_pkg::OP_ADD: begin
                result = sum;
            end
            tiny_cpu_pkg::OP_SUB: begin
                result = diff;
            end
            tiny_cpu_pkg::OP_AND: begin
                result = a & b;
            end
            tiny_cpu_pkg::OP_OR: begin
                result = a | b;
            end
            tiny_cpu_pkg::OP_XOR: begin
                result = a ^ b;
            end
            default: begin
                // NOP, OUT, HALT, LI are not ALU writes
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none

module register_file (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  tiny_cpu_pkg::reg_wr_t                    wr,        // Writeback from control
    input  logic [tiny_cpu_pkg::reg_addr_width-1:0]  rd_a_addr, // r_a field
    input  logic [tiny_cpu_pkg::reg_addr_width-1:0]  rd_b_addr, // r_b field
    output logic [tiny_cpu_pkg::data_width-1:0]      rd_a_data, // To ALU a and OUT path
    output logic [tiny_cpu_pkg::data_width-1:0]      rd_b_data  // To ALU b
);

    localparam int num_regs = 2 ** tiny_cpu_pkg::reg_addr_width; // Four registers

    logic [tiny_cpu_pkg::data_width-1:0] regs_q [num_regs]; // R0..R3

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs_q[i] <= '0; // Registers read 0 after reset
            end
        end else if (wr.en) begin
            regs_q[wr.addr] <= wr.data; // Single write port
        end
    end

    // Asynchronous reads, same-cycle operands for the ALU
    assign rd_a_data = regs_q[rd_a_addr];
    assign rd_b_data = regs_q[rd_b_addr];

    // Control must never issue a write to an undefined register
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr.en |-> !$isunknown(wr.addr)
    ) else $error("register write with unknown address");

endmodule

`default_nettype wire

// ==== instruction_parser.sv ====
`default_nettype none

module instruction_parser (
    input  logic [tiny_cpu_pkg::instr_width-1:0] instruction, // Raw 9-bit word
    output tiny_cpu_pkg::decoded_instr_t         decoded      // Op, registers, immediate
);

    // Raw opcode field, bits 6:4
    typedef enum logic [2:0] {
        FLD_SPECIAL = 3'b000, // NOP or MOV alias
        FLD_ADD     = 3'b001,
        FLD_SUB     = 3'b010,
        FLD_AND     = 3'b011,
        FLD_OR      = 3'b100,
        FLD_XOR     = 3'b101,
        FLD_OUT     = 3'b110,
        FLD_HALT    = 3'b111
    } op_field_e;

    op_field_e                                   op_field; // Bits 6:4
    logic [tiny_cpu_pkg::reg_addr_width-1:0]     fld_a;    // Bits 3:2
    logic [tiny_cpu_pkg::reg_addr_width-1:0]     fld_b;    // Bits 1:0
    logic [tiny_cpu_pkg::data_width-1:0]         imm_sext; // Bits 6:0 sign-extended

    assign op_field = op_field_e'(instruction[6:4]);
    assign fld_a    = instruction[3:2];
    assign fld_b    = instruction[1:0];
    assign imm_sext = {{(tiny_cpu_pkg::data_width - tiny_cpu_pkg::imm_src_width)
                        {instruction[tiny_cpu_pkg::imm_src_width-1]}},
                       instruction[tiny_cpu_pkg::imm_src_width-1:0]};

    always_comb begin
        decoded.op  = tiny_cpu_pkg::OP_NOP; // Defaults, bit 7 never looked at
        decoded.r_a = fld_a;
        decoded.r_b = fld_b;
        decoded.imm = '0;                   // Only LI carries an immediate
        if (instruction[8]) begin           // LI overrides every other field
            decoded.op  = tiny_cpu_pkg::OP_LI;
            decoded.r_a = '0;               // Always targets R0
            decoded.r_b = '0;
            decoded.imm = imm_sext;
        end else begin
            unique case (op_field)
                FLD_SPECIAL: begin
                    // Twelve aliases with distinct fields copy r_b into r_a
                    if (fld_a != fld_b) begin
                        decoded.op = tiny_cpu_pkg::OP_MOV;
                    end else begin
                        decoded.op = tiny_cpu_pkg::OP_NOP;
                    end
                end
                FLD_ADD:  decoded.op = tiny_cpu_pkg::OP_ADD;
                FLD_SUB:  decoded.op = tiny_cpu_pkg::OP_SUB;
                FLD_AND:  decoded.op = tiny_cpu_pkg::OP_AND;
                FLD_OR:   decoded.op = tiny_cpu_pkg::OP_OR;
                FLD_XOR:  decoded.op = tiny_cpu_pkg::OP_XOR;
                FLD_OUT:  decoded.op = tiny_cpu_pkg::OP_OUT;
                FLD_HALT: decoded.op = tiny_cpu_pkg::OP_HALT;
                default:  decoded.op = tiny_cpu_pkg::OP_NOP; // X field only
            endcase
        end
    end

    // Known word must give a known op, deferred to skip glitches
    always_comb begin
        if (!$isunknown(instruction)) begin
            a_op_known: assert final (!$isunknown(decoded.op))
                else $error("parser produced unknown op for 0x%03h", instruction);
        end
    end

endmodule

`default_nettype wire

// ==== tiny_cpu_pkg.sv ====
`default_nettype none

package tiny_cpu_pkg;

    localparam int data_width     = 8;  // Register and bus width
    localparam int instr_width    = 9;  // Instruction word width
    localparam int reg_addr_width = 2;  // R0..R3
    localparam int prog_depth     = 32; // Program memory words
    localparam int pc_width       = 5;  // log2(prog_depth)
    localparam int imm_src_width  = 7;  // LI payload bits 6:0

    // All-zero word decodes as NOP (opcode 000, r_a == r_b)
    localparam logic [instr_width-1:0] nop_word = '0;

    // Decoded operation, after MOV alias and LI detection
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,  // Opcode 000 with equal registers
        OP_MOV  = 4'd1,  // Opcode 000 with different registers
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_OUT  = 4'd7,  // Present R[r_a] on the output port
        OP_HALT = 4'd8,
        OP_LI   = 4'd9   // Bit 8 set, load R0 with immediate
    } cpu_op_e;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0, // Waiting for start after reset
        ST_FETCH  = 2'd1, // Memory registers word at pc
        ST_EXEC   = 2'd2, // Decode, execute, write back
        ST_HALTED = 2'd3  // HALT seen, done high
    } ctrl_state_e;

    // Parser output, 16 bits
    typedef struct packed {
        cpu_op_e                   op;  // Decoded operation
        logic [reg_addr_width-1:0] r_a; // Destination / first source
        logic [reg_addr_width-1:0] r_b; // Second source
        logic [data_width-1:0]     imm; // Sign-extended LI value
    } decoded_instr_t;

    // Register file write request, 11 bits
    typedef struct packed {
        logic                      en;   // Write strobe
        logic [reg_addr_width-1:0] addr; // Target register
        logic [data_width-1:0]     data; // Write value
    } reg_wr_t;

endpackage

`default_nettype wire
